//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;      // data word or byte address
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // branch conditions
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    // alu functions, shared by OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,      // zero value, so a cleared record adds
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B    // lui
    } alu_op_e;

    localparam inst_t NOP_INST = 32'h0000_0013;   // addi x0, x0, 0

endpackage

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;
    import rv_isa_pkg::*;

    // decode -> execute
    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1;         // zero when the format has no rs1
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      reg_wen;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jal;
        funct3_t   funct3;
    } id_ex_t;

    // execute -> memory
    typedef struct packed {
        word_t     alu_result;  // also the load/store address
        word_t     store_data;
        word_t     pc_plus_4;
        reg_addr_t rd;
        logic      reg_wen;
        logic      is_load;
        logic      is_store;
        logic      is_link;
    } ex_mem_t;

    // memory -> writeback
    typedef struct packed {
        word_t     value;
        reg_addr_t rd;
        logic      reg_wen;
    } mem_wb_t;

    typedef struct packed {
        logic  valid;
        word_t addr;            // byte address of the stored word
        word_t data;
    } store_t;

    // result on its way back to execute
    typedef struct packed {
        logic      reg_wen;
        reg_addr_t rd;
        word_t     value;
    } fwd_t;

endpackage

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t raddr1_i,
    input  wire reg_addr_t raddr2_i,
    output word_t          rdata1_o,
    output word_t          rdata2_o,
    input  wire mem_wb_t   wb_i
);
    word_t regs [1:31];     // x0 has no storage
    logic  wr_en;

    assign wr_en = wb_i.reg_wen && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (wb_i.rd == addr)) begin
            return wb_i.value;      // write in flight wins
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire inst_t     inst_i,
    input  wire word_t     pc_i,
    input  wire mem_wb_t   wb_i,
    output reg_addr_t      rs1_o,
    output reg_addr_t      rs2_o,
    output id_ex_t         id_ex_o
);
    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rs1, rs2, rd;
    word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t     rdata1, rdata2;
    logic      use_rs1, use_rs2;
    id_ex_t    rec;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb_i)
    );

    // alt is funct7 bit 5: sub / sra
    function automatic alu_op_e alu_decode(input funct3_t f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    always_comb begin
        rec        = '0;        // unknown opcode stays a bubble
        rec.pc     = pc_i;
        rec.rd     = rd;
        rec.funct3 = funct3;
        rec.imm    = imm_i;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (opcode)
            OPC_OP: begin
                rec.alu_op  = alu_decode(funct3, inst_i[30]);
                rec.reg_wen = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            OPC_OP_IMM: begin
                // imm bit 10 only means sra for the shift encoding
                rec.alu_op      = alu_decode(funct3, (funct3 == F3_SRL_SRA) && inst_i[30]);
                rec.alu_src_imm = 1'b1;
                rec.reg_wen     = 1'b1;
                use_rs1         = 1'b1;
            end
            OPC_LUI: begin
                rec.alu_op      = ALU_PASS_B;
                rec.alu_src_imm = 1'b1;
                rec.reg_wen     = 1'b1;
                rec.imm         = imm_u;
            end
            OPC_LOAD: begin
                rec.alu_src_imm = 1'b1;     // address = rs1 + imm
                rec.reg_wen     = 1'b1;
                rec.is_load     = 1'b1;
                use_rs1         = 1'b1;
            end
            OPC_STORE: begin
                rec.alu_src_imm = 1'b1;
                rec.is_store    = 1'b1;
                rec.imm         = imm_s;
                use_rs1         = 1'b1;
                use_rs2         = 1'b1;
            end
            OPC_BRANCH: begin
                rec.is_branch = 1'b1;
                rec.imm       = imm_b;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OPC_JAL: begin
                rec.is_jal  = 1'b1;
                rec.reg_wen = 1'b1;
                rec.imm     = imm_j;
            end
            default: ;
        endcase
        rec.rs1      = use_rs1 ? rs1 : '0;   // unused fields never stall or forward
        rec.rs2      = use_rs2 ? rs2 : '0;
        rec.rs1_data = rdata1;
        rec.rs2_data = rdata2;
    end

    assign id_ex_o = rec;
    assign rs1_o   = rec.rs1;
    assign rs2_o   = rec.rs2;

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire id_ex_t id_ex_i,
    input  wire fwd_t   mem_fwd_i,
    input  wire fwd_t   wb_fwd_i,
    output ex_mem_t     ex_mem_o,
    output logic        take_branch_o,
    output word_t       target_pc_o
);
    word_t op_a;
    word_t op_b_reg;    // rs2 after forwarding, also the store data
    word_t op_b;
    word_t alu_res;
    logic  cond;

    // memory stage is younger, so it wins over writeback
    function automatic word_t fwd_pick(input reg_addr_t idx, input word_t reg_val,
                                       input fwd_t mem_f, input fwd_t wb_f);
        if (idx == '0) begin
            return reg_val;
        end
        if (mem_f.reg_wen && (mem_f.rd == idx)) begin
            return mem_f.value;
        end
        if (wb_f.reg_wen && (wb_f.rd == idx)) begin
            return wb_f.value;
        end
        return reg_val;
    endfunction

    assign op_a     = fwd_pick(id_ex_i.rs1, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign op_b_reg = fwd_pick(id_ex_i.rs2, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);
    assign op_b     = id_ex_i.alu_src_imm ? id_ex_i.imm : op_b_reg;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            default:  alu_res = op_b;      // pass b
        endcase
    end

    // compare uses the register operands, not the immediate
    always_comb begin
        case (id_ex_i.funct3)
            F3_BEQ:  cond = (op_a == op_b_reg);
            F3_BNE:  cond = (op_a != op_b_reg);
            F3_BLT:  cond = ($signed(op_a) < $signed(op_b_reg));
            F3_BGE:  cond = ($signed(op_a) >= $signed(op_b_reg));
            default: cond = 1'b0;
        endcase
    end

    assign take_branch_o = (id_ex_i.is_branch && cond) || id_ex_i.is_jal;
    assign target_pc_o   = id_ex_i.pc + id_ex_i.imm;

    assign ex_mem_o = '{
        alu_result: alu_res,
        store_data: op_b_reg,
        pc_plus_4:  id_ex_i.pc + 32'd4,
        rd:         id_ex_i.rd,
        reg_wen:    id_ex_i.reg_wen,
        is_load:    id_ex_i.is_load,
        is_store:   id_ex_i.is_store,
        is_link:    id_ex_i.is_jal     // writeback takes pc+4
    };

endmodule

`default_nettype wire

//--- result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import rv_isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  wire          clk,
    input  wire          rst_n,
    input  wire ex_mem_t ex_mem_i,
    output store_t       store_o,
    output fwd_t         mem_fwd_o,
    output fwd_t         wb_fwd_o,
    output mem_wb_t      wb_o
);
    localparam int IDX_W = $clog2(DMEM_WORDS);

    ex_mem_t          mem_q;
    mem_wb_t          wb_q;
    word_t            dmem [DMEM_WORDS];
    logic [IDX_W-1:0] ram_idx;
    word_t            ram_rdata;
    word_t            mem_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_q <= '0;
        end else begin
            mem_q <= ex_mem_i;
        end
    end

    assign ram_idx = mem_q.alu_result[IDX_W+1:2];   // word index

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_q.is_store) begin
            dmem[ram_idx] <= mem_q.store_data;
        end
    end

    assign ram_rdata = dmem[ram_idx];
    assign mem_value = mem_q.is_link ? mem_q.pc_plus_4 :
                       mem_q.is_load ? ram_rdata : mem_q.alu_result;

    assign store_o   = '{valid: mem_q.is_store, addr: mem_q.alu_result, data: mem_q.store_data};
    assign mem_fwd_o = '{reg_wen: mem_q.reg_wen, rd: mem_q.rd, value: mem_value};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= '{value: mem_value, rd: mem_q.rd, reg_wen: mem_q.reg_wen};
        end
    end

    assign wb_o     = wb_q;
    assign wb_fwd_o = '{reg_wen: wb_q.reg_wen, rd: wb_q.rd, value: wb_q.value};

    // stores land on a whole word inside the ram
    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_q.is_store |-> (mem_q.alu_result[1:0] == 2'b00)
                           && ((mem_q.alu_result >> 2) < DMEM_WORDS));

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import rv_isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  wire        clk,
    input  wire        rst_n,
    output word_t      imem_addr_o,
    input  wire inst_t imem_data_i,
    output store_t     store_o
);
    localparam word_t RESET_PC = 32'h0000_0000;

    word_t     pc_q;
    word_t     if_pc_q;
    inst_t     if_inst_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_mem_t   ex_mem;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;
    mem_wb_t   wb;
    reg_addr_t id_rs1, id_rs2;
    word_t     target_pc;
    logic      take_branch;
    logic      stall;

    // load in execute feeding the instruction in decode
    assign stall = id_ex_q.is_load && (id_ex_q.rd != '0)
                   && ((id_ex_q.rd == id_rs1) || (id_ex_q.rd == id_rs2));

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (take_branch) begin
            pc_q <= target_pc;
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_pc_q   <= RESET_PC;
            if_inst_q <= NOP_INST;
        end else if (take_branch) begin
            if_inst_q <= NOP_INST;     // squash the fetch slot
        end else if (!stall) begin
            if_pc_q   <= pc_q;
            if_inst_q <= imem_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q <= '0;
        end else if (take_branch || stall) begin
            id_ex_q <= '0;             // bubble
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    decode_stage u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_i  (if_inst_q),
        .pc_i    (if_pc_q),
        .wb_i    (wb),
        .rs1_o   (id_rs1),
        .rs2_o   (id_rs2),
        .id_ex_o (id_ex_d)
    );

    execute_stage u_execute (
        .id_ex_i       (id_ex_q),
        .mem_fwd_i     (mem_fwd),
        .wb_fwd_i      (wb_fwd),
        .ex_mem_o      (ex_mem),
        .take_branch_o (take_branch),
        .target_pc_o   (target_pc)
    );

    result_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem_i  (ex_mem),
        .store_o   (store_o),
        .mem_fwd_o (mem_fwd),
        .wb_fwd_o  (wb_fwd),
        .wb_o      (wb)
    );

    // fetch address stays word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import rv_isa_pkg::*;
    import pipe_pkg::*;
();
    localparam int DMEM_WORDS      = 256;
    localparam int PROG_LEN        = 200;
    localparam int BODY_END        = PROG_LEN - 8;   // closing store block starts here
    localparam int CLK_NS          = 100;
    localparam int WATCHDOG_CYCLES = 4 * PROG_LEN + 100;

    logic        clk;
    logic        rst_n;
    word_t       imem_addr;
    inst_t       imem_data;
    store_t      store;
    inst_t       prog [PROG_LEN];
    word_t       exp_addr [$];      // stores in program order
    word_t       exp_data [$];
    logic [31:0] rng = 32'h5eea_f774;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk_o(clk));

    core_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .store_o     (store)
    );

    // same-cycle instruction read, nop past the end
    assign imem_data = (imem_addr < PROG_LEN * 4) ? prog[imem_addr[9:2]] : NOP_INST;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic inst_t r_type(input logic alt, input funct3_t f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(input opcode_t op, input funct3_t f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t s_type(input reg_addr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};   // sw, base x0
    endfunction

    function automatic inst_t b_type(input funct3_t f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t j_type(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t alu_ref(input funct3_t f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken_ref(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        reg_addr_t   rd, rs1, rs2;
        funct3_t     f3;
        int          jmp;
        r = next_random();
        prog[0] = {r[31:12], 5'd1, OPC_LUI};
        prog[1] = i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd1, 5'd1, r[11:0]);
        prog[2] = s_type(5'd1, 12'd0);                       // lowest word
        prog[3] = s_type(5'd1, 12'(4 * (DMEM_WORDS - 1)));   // highest word
        for (int i = 4; i < BODY_END; i++) begin
            r   = next_random();
            rd  = {2'b0, r[6:4]};      // x0..x7 only
            rs1 = {2'b0, r[9:7]};
            rs2 = {2'b0, r[12:10]};
            f3  = r[15:13];
            jmp = 4 * (2 + int'(r[31:29]) % 5);
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
                    prog[i] = r_type((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && r[16],
                                     f3, rd, rs1, rs2);
                4'd5, 4'd6, 4'd7: begin
                    // only addi, slti, xori, ori, andi
                    if (f3 == F3_SLL || f3 == F3_SLTU || f3 == F3_SRL_SRA) begin
                        f3 = F3_ADD_SUB;
                    end
                    prog[i] = i_type(OPC_OP_IMM, f3, rd, rs1, r[28:17]);
                end
                4'd8: prog[i] = {r[31:12], rd, OPC_LUI};
                4'd9, 4'd10: prog[i] = i_type(OPC_LOAD, 3'b010, rd, 5'd0, {2'b0, r[24:17], 2'b0});
                4'd11, 4'd12: prog[i] = s_type(rs2, {2'b0, r[24:17], 2'b0});
                4'd13, 4'd14: prog[i] = b_type({r[14], 1'b0, r[13]}, rs1, rs2, 13'(jmp));
                default: prog[i] = j_type(rd, 21'(jmp));
            endcase
        end
        for (int j = 1; j < 8; j++) begin
            prog[BODY_END + j - 1] = s_type(reg_addr_t'(j), 12'(4 * j));
        end
        prog[PROG_LEN - 1] = j_type(5'd0, 21'd0);   // jal x0, 0 parks the core
    endtask

    // sequential execution, one instruction at a time
    task automatic run_model();
        word_t     x [32];
        word_t     ram [DMEM_WORDS];
        inst_t     w;
        word_t     a, b, addr, res;
        reg_addr_t rd;
        logic      wen;
        int        pc, next;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ram[i] = '0;
        end
        pc = 0;
        while (pc != PROG_LEN - 1) begin
            w    = prog[pc];
            rd   = w[11:7];
            a    = x[w[19:15]];
            b    = x[w[24:20]];
            wen  = 1'b0;
            res  = '0;
            next = pc + 1;
            case (w[6:0])
                OPC_OP: begin
                    wen = 1'b1;
                    res = alu_ref(w[14:12], w[30], a, b);
                end
                OPC_OP_IMM: begin
                    wen = 1'b1;
                    res = alu_ref(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
                end
                OPC_LUI: begin
                    wen = 1'b1;
                    res = {w[31:12], 12'b0};
                end
                OPC_LOAD: begin
                    wen  = 1'b1;
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = ram[int'(addr >> 2)];
                end
                OPC_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    ram[int'(addr >> 2)] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                OPC_BRANCH: begin
                    if (taken_ref(w[14:12], a, b)) begin
                        next = pc + int'($signed({{19{w[31]}}, w[31], w[7], w[30:25],
                                                  w[11:8], 1'b0})) / 4;
                    end
                end
                default: begin   // jal
                    wen  = 1'b1;
                    res  = word_t'(4 * (pc + 1));
                    next = pc + int'($signed({{11{w[31]}}, w[31], w[19:12], w[20],
                                              w[30:21], 1'b0})) / 4;
                end
            endcase
            if (wen && rd != '0) begin
                x[rd] = res;
            end
            pc = next;
        end
    endtask

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // store port is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (rst_n && store.valid) begin
            if (exp_addr.size() == 0) begin
                $display("core stored %h to address %h but the model made no such store",
                         store.data, store.addr);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end else begin
                check_equal(store.addr, exp_addr.pop_front(), "store address");
                check_equal(store.data, exp_data.pop_front(), "store data");
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("timeout after %0d cycles with %0d stores still outstanding",
                 WATCHDOG_CYCLES, exp_addr.size());
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        rst_n = 1'b0;
        gen_program();
        run_model();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);   // room for a stray store to show up
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rv_isa_pkg.sv
pipe_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
tb_clock.sv
tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_core -o Vtb_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
